//--- dfdIfs.sv
/* Connections between the register block, the trace units and the funnel.
   One instance of each interface per trace unit. */

`default_nettype none

// Unit configuration from the registers, drop count back to them
interface unitCfgIf
  import dfdPkg::*;
();
  logic [SEL_W-1:0] muxSel;
  logic traceEn;
  logic stallMode;
  logic [DROP_CNT_W-1:0] dropCount;

  modport regs(
    output muxSel,
    output traceEn,
    output stallMode,
    input dropCount
  );

  modport unit(
    input muxSel,
    input traceEn,
    input stallMode,
    output dropCount
  );
endinterface

// Valid/ready stream of captured samples
interface traceStreamIf
  import dfdPkg::*;
();
  logic valid;
  logic ready;
  logic [SEL_W-1:0] muxSel;
  seq_t seq;
  hwWord_t data;

  modport source(
    output valid,
    output muxSel,
    output seq,
    output data,
    input ready
  );

  modport sink(
    input valid,
    input muxSel,
    input seq,
    input data,
    output ready
  );
endinterface

`default_nettype wire

//--- dfdPkg.sv
/* Types shared by the trace units, the funnel and the register block.
   Import with dfdPkg::* in the module header. */

`default_nettype none

`include "dfd_config.svh"

package dfdPkg;

  localparam int SEL_W = $clog2(`DFD_HW_WORDS);
  localparam int UNIT_ID_W = $clog2(`DFD_NUM_UNITS);
  localparam int LEVEL_W = $clog2(`DFD_FIFO_DEPTH) + 1;
  localparam int DROP_CNT_W = 16;
  localparam int REG_IDX_W = 4;

  typedef logic [`DFD_WORD_W-1:0] hwWord_t;
  typedef logic [`DFD_SEQ_W-1:0] seq_t;

  // One buffer entry as seen by the funnel
  typedef struct packed {
    logic valid;
    logic [UNIT_ID_W-1:0] unitId;
    logic [SEL_W-1:0] muxSel;
    seq_t seq;
    hwWord_t data;
  } traceEntry_s;

  // Same entry as the raw bus word
  typedef union packed {
    traceEntry_s pkt;
    logic [`DFD_WB_DATA_W-1:0] raw;
  } traceEntry_u;

  typedef struct packed {
    logic [SEL_W-1:0] muxSel;
    logic traceEn;
    logic stallMode;
  } unitCfg_s;

  typedef enum logic [REG_IDX_W-1:0] {
    REG_STATUS = 4'd0,
    REG_DATA = 4'd1,
    REG_UNIT_CFG0 = 4'd2,
    REG_UNIT_CFG1 = 4'd3,
    REG_UNIT_CFG2 = 4'd4,
    REG_UNIT_CFG3 = 4'd5,
    REG_DROP_COUNT0 = 4'd6,
    REG_DROP_COUNT1 = 4'd7,
    REG_DROP_COUNT2 = 4'd8,
    REG_DROP_COUNT3 = 4'd9
  } regIdx_e;

endpackage

`default_nettype wire

//--- dfdRegs.sv
/* Wishbone classic register block. Holds the per-unit trace configuration,
   returns drop counts and buffer level, and pops the buffer on DATA reads. */

`default_nettype none

`include "dfd_config.svh"

module dfdRegs
  import dfdPkg::*;
(
  input  logic                      clk,
  input  logic                      i_arstN,
  input  logic                      i_wbCyc,
  input  logic                      i_wbStb,
  input  logic                      i_wbWe,
  input  logic [`DFD_WB_ADDR_W-1:0] i_wbAdr,
  input  logic [`DFD_WB_DATA_W-1:0] i_wbDat,
  output logic [`DFD_WB_DATA_W-1:0] o_wbDat,
  output logic                      o_wbAck,
  unitCfgIf.regs                    o_cfg [`DFD_NUM_UNITS],
  input  logic [LEVEL_W-1:0]        i_level,
  input  traceEntry_u               i_head,
  output logic                      o_pop
);

  localparam int DATA_W = `DFD_WB_DATA_W;
  localparam int WORD_IDX_W = `DFD_WB_ADDR_W - 2;
  localparam int NUM_REGS = 2 + 2 * `DFD_NUM_UNITS;
  localparam int CFG_W = $bits(unitCfg_s);

  logic [WORD_IDX_W-1:0] wordIdx;
  logic mapped;
  regIdx_e regIdx;
  logic isCfg;
  logic isDrop;
  logic [UNIT_ID_W-1:0] unitSel;
  logic req;
  logic wrEn;
  logic ackQ;
  logic [DATA_W-1:0] rdData;
  unitCfg_s cfgQ [`DFD_NUM_UNITS];
  logic [DROP_CNT_W-1:0] dropCounts [`DFD_NUM_UNITS];

  // ************************************************************************
  // Address decode
  // ************************************************************************

  assign wordIdx = i_wbAdr[`DFD_WB_ADDR_W-1:2];
  assign mapped = wordIdx < WORD_IDX_W'(NUM_REGS);
  assign regIdx = regIdx_e'(wordIdx[REG_IDX_W-1:0]);

  always_comb begin
    isCfg = mapped && (regIdx inside {[REG_UNIT_CFG0:REG_UNIT_CFG3]});
    isDrop = mapped && (regIdx inside {[REG_DROP_COUNT0:REG_DROP_COUNT3]});
    // Low bits give the unit in both the CFG and DROP_COUNT groups
    unitSel = UNIT_ID_W'(regIdx - REG_UNIT_CFG0);
  end

  always_comb begin
    rdData = '0;
    if (isCfg) begin
      rdData = DATA_W'(cfgQ[unitSel]);
    end else if (isDrop) begin
      rdData = DATA_W'(dropCounts[unitSel]);
    end else if (mapped && regIdx == REG_STATUS) begin
      rdData = DATA_W'(i_level);
    end else if (mapped && regIdx == REG_DATA) begin
      rdData = i_head.raw;
    end
  end

  // ************************************************************************
  // Bus handshake and configuration
  // ************************************************************************

  assign req = i_wbCyc && i_wbStb;
  // Writes land on the first cycle of the access
  assign wrEn = req && i_wbWe && !ackQ;

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      ackQ <= 1'b0;
    end else begin
      ackQ <= req && !ackQ;
    end
  end

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      for (int u = 0; u < `DFD_NUM_UNITS; u++) begin
        cfgQ[u] <= '0;
      end
    end else if (wrEn && isCfg) begin
      cfgQ[unitSel] <= unitCfg_s'(i_wbDat[CFG_W-1:0]);
    end
  end

  assign o_wbAck = ackQ;
  assign o_wbDat = rdData;
  assign o_pop = ackQ && req && !i_wbWe && mapped && regIdx == REG_DATA;

  for (genvar g = 0; g < `DFD_NUM_UNITS; g++) begin : gCfg
    assign o_cfg[g].muxSel = cfgQ[g].muxSel;
    assign o_cfg[g].traceEn = cfgQ[g].traceEn;
    assign o_cfg[g].stallMode = cfgQ[g].stallMode;
    assign dropCounts[g] = o_cfg[g].dropCount;
  end

  // Host keeps the request up until it sees ack
  aAckInCycle: assert property (@(posedge clk) disable iff (!i_arstN)
    o_wbAck |-> i_wbCyc && i_wbStb);

endmodule

`default_nettype wire

//--- dfdTop.f
+incdir+.
dfdPkg.sv
dfdIfs.sv
dfdRegs.sv
traceUnit.sv
traceFunnel.sv
dfdTop.sv
tbDfdTop.sv

//--- dfdTop.sv
/* Top of the debug trace block. Wishbone host port, per-unit debug words
   and trace control in, stall flags out. */

`default_nettype none

`include "dfd_config.svh"

module dfdTop
  import dfdPkg::*;
(
  input  logic                                           clk,
  input  logic                                           i_arstN,
  // Wishbone classic slave
  input  logic                                           i_wbCyc,
  input  logic                                           i_wbStb,
  input  logic                                           i_wbWe,
  input  logic [`DFD_WB_ADDR_W-1:0]                      i_wbAdr,
  input  logic [`DFD_WB_DATA_W-1:0]                      i_wbDat,
  output logic [`DFD_WB_DATA_W-1:0]                      o_wbDat,
  output logic                                           o_wbAck,
  // Debug words and trace control, per unit
  input  hwWord_t [`DFD_NUM_UNITS-1:0][`DFD_HW_WORDS-1:0] i_hw,
  input  logic [`DFD_NUM_UNITS-1:0]                      i_timeTick,
  input  logic [`DFD_NUM_UNITS-1:0]                      i_traceStart,
  input  logic [`DFD_NUM_UNITS-1:0]                      i_traceStop,
  input  logic [`DFD_NUM_UNITS-1:0]                      i_tracePulse,
  output logic [`DFD_NUM_UNITS-1:0]                      o_stall
);

  logic [LEVEL_W-1:0] level;
  traceEntry_u head;
  logic pop;

  unitCfgIf cfgIf [`DFD_NUM_UNITS] ();
  traceStreamIf streamIf [`DFD_NUM_UNITS] ();

  dfdRegs uRegs (
    .clk     (clk),
    .i_arstN (i_arstN),
    .i_wbCyc (i_wbCyc),
    .i_wbStb (i_wbStb),
    .i_wbWe  (i_wbWe),
    .i_wbAdr (i_wbAdr),
    .i_wbDat (i_wbDat),
    .o_wbDat (o_wbDat),
    .o_wbAck (o_wbAck),
    .o_cfg   (cfgIf),
    .i_level (level),
    .i_head  (head),
    .o_pop   (pop)
  );

  for (genvar g = 0; g < `DFD_NUM_UNITS; g++) begin : gUnit
    traceUnit uUnit (
      .clk          (clk),
      .i_arstN      (i_arstN),
      .i_hw         (i_hw[g]),
      .i_timeTick   (i_timeTick[g]),
      .i_traceStart (i_traceStart[g]),
      .i_traceStop  (i_traceStop[g]),
      .i_tracePulse (i_tracePulse[g]),
      .io_cfg       (cfgIf[g]),
      .o_stream     (streamIf[g]),
      .o_stall      (o_stall[g])
    );
  end

  traceFunnel uFunnel (
    .clk       (clk),
    .i_arstN   (i_arstN),
    .i_streams (streamIf),
    .i_pop     (pop),
    .o_level   (level),
    .o_head    (head)
  );

endmodule

`default_nettype wire

//--- dfd_config.svh
/* Build-time sizes of the debug trace block.
   Included wherever a size or a bus width is needed. */

`ifndef DFD_CONFIG_SVH
`define DFD_CONFIG_SVH

// Trace units and their debug inputs
`define DFD_NUM_UNITS 4
`define DFD_HW_WORDS 16
`define DFD_WORD_W 16

// Per-unit sequence number
`define DFD_SEQ_W 9

// Trace buffer entries
`define DFD_FIFO_DEPTH 32

// Wishbone classic slave
`define DFD_WB_ADDR_W 8
`define DFD_WB_DATA_W 32

`endif

//--- run.sh
#!/bin/sh
# Compile and run the debug trace block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbDfdTop -f dfdTop.f -o simDfdTop
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simDfdTop
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- tbDfdTop.sv
/* Testbench for the debug trace block. Drives random trace control and host
   accesses, and checks every read against a capture model kept here. */

`default_nettype none

`include "dfd_config.svh"

module tbDfdTop
  import dfdPkg::*;
();

  localparam int N = `DFD_NUM_UNITS;
  localparam int DEPTH = `DFD_FIFO_DEPTH;
  localparam int SEQ_SPAN = 1 << `DFD_SEQ_W;
  localparam int CFG_W = $bits(unitCfg_s);
  localparam int TRACE_ROUNDS = 4;
  localparam int ROUND_CYCLES = 80;
  localparam int OVF_CYCLES = 120;
  localparam int STALL_CYCLES = 200;
  localparam int RESET_CYCLES = 4 * 6;
  localparam int CAPTURE_CYCLES =
    TRACE_ROUNDS * ROUND_CYCLES + OVF_CYCLES + STALL_CYCLES + RESET_CYCLES;
  localparam int DRAIN_ACCESSES = 2 * (DEPTH + N) + 2 + N;
  localparam int WB_ACCESSES =
    51 + N * (TRACE_ROUNDS + 2) + 3 * DRAIN_ACCESSES + TRACE_ROUNDS + 2;
  localparam int CYCLE_LIMIT = 2 * (CAPTURE_CYCLES + 4 * WB_ACCESSES);

  logic clk;
  logic arstN;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [`DFD_WB_ADDR_W-1:0] wbAdr;
  logic [`DFD_WB_DATA_W-1:0] wbDatIn;
  logic [`DFD_WB_DATA_W-1:0] o_wbDat;
  logic o_wbAck;
  hwWord_t [N-1:0][`DFD_HW_WORDS-1:0] hw;
  logic [N-1:0] timeTick;
  logic [N-1:0] traceStart;
  logic [N-1:0] traceStop;
  logic [N-1:0] tracePulse;
  logic [N-1:0] o_stall;

  // Capture model
  logic [15:0] lfsrState;
  logic [N-1:0] active;
  unitCfg_s cfgModel [N];
  hwWord_t expData [N][SEQ_SPAN];
  logic [SEL_W-1:0] expSel [N][SEQ_SPAN];
  int capCount [N];
  int lastSeq [N];
  int readCount [N];
  int dropRead [N];
  bit burstDone;
  bit stallSeen;
  int cycleCount = 0;

  dfdTop i_dut (
    .clk          (clk),
    .i_arstN      (arstN),
    .i_wbCyc      (wbCyc),
    .i_wbStb      (wbStb),
    .i_wbWe       (wbWe),
    .i_wbAdr      (wbAdr),
    .i_wbDat      (wbDatIn),
    .o_wbDat      (o_wbDat),
    .o_wbAck      (o_wbAck),
    .i_hw         (hw),
    .i_timeTick   (timeTick),
    .i_traceStart (traceStart),
    .i_traceStop  (traceStop),
    .i_tracePulse (tracePulse),
    .o_stall      (o_stall)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      failRun($sformatf("cycle limit of %0d reached before the tests finished", CYCLE_LIMIT));
    end
  end

  // ************************************************************************
  // Random numbers and checks
  // ************************************************************************

  function automatic logic lfsrStep();
    logic b;
    b = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (b) begin
      lfsrState = lfsrState ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrStep()};
    end
    return v;
  endfunction

  task automatic failRun(string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkEntry(string name, traceEntry_u got, traceEntry_u exp);
    if (got.raw !== exp.raw) begin
      failRun($sformatf("mismatch %s got 0x%h expected 0x%h", name, got.raw, exp.raw));
    end
  endtask

  task automatic checkWord(string name, logic [`DFD_WB_DATA_W-1:0] got,
                           logic [`DFD_WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ************************************************************************
  // Host and trace drivers
  // ************************************************************************

  task automatic applyReset();
    @(negedge clk);
    arstN = 1'b0;
    repeat (4) @(negedge clk);
    arstN = 1'b1;
    active = '0;
    for (int u = 0; u < N; u++) begin
      cfgModel[u] = '0;
      capCount[u] = 0;
      lastSeq[u] = -1;
      readCount[u] = 0;
    end
  endtask

  // One classic cycle, request held until the ack edge has passed
  task automatic wbAccess(bit we, int idx, logic [31:0] wdata, output logic [31:0] rdata);
    int waitCycles;
    @(negedge clk);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = `DFD_WB_ADDR_W'(idx * 4);
    wbDatIn = wdata;
    waitCycles = 0;
    do begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles > 4) begin
        failRun($sformatf("no ack for the access to register %0d", idx));
      end
    end while (!o_wbAck);
    rdata = o_wbDat;
    @(negedge clk);
    checkBit("o_wbAck", o_wbAck, 1'b0);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
  endtask

  task automatic writeCfg(int u, unitCfg_s c);
    logic [31:0] d;
    wbAccess(1'b1, int'(REG_UNIT_CFG0) + u, 32'(c), d);
    cfgModel[u] = c;
  endtask

  task automatic driveTraceCycle(bit randCtl, bit stallAware);
    logic tick;
    logic pulse;
    logic start;
    logic stop;
    @(negedge clk);
    for (int u = 0; u < N; u++) begin
      for (int w = 0; w < `DFD_HW_WORDS; w++) begin
        hw[u][w] = hwWord_t'(randBits(`DFD_WORD_W));
      end
      tick = randBits(1) != 0;
      pulse = randBits(4) == 0;
      start = randCtl ? randBits(3) == 0 : 1'b1;
      stop = randCtl ? randBits(3) == 0 : 1'b0;
      if (!cfgModel[u].stallMode) begin
        checkBit($sformatf("o_stall[%0d]", u), o_stall[u], 1'b0);
      end
      // Host holds off a stalled unit
      if (stallAware && o_stall[u]) begin
        tick = 1'b0;
        pulse = 1'b0;
        stallSeen = 1'b1;
      end
      if (cfgModel[u].traceEn && ((active[u] && tick) || pulse)) begin
        if (capCount[u] >= SEQ_SPAN) begin
          failRun("capture model ran past the sequence range");
        end
        expData[u][capCount[u]] = hw[u][cfgModel[u].muxSel];
        expSel[u][capCount[u]] = cfgModel[u].muxSel;
        capCount[u]++;
      end
      if (stop) begin
        active[u] = 1'b0;
      end else if (start) begin
        active[u] = 1'b1;
      end
      timeTick[u] = tick;
      tracePulse[u] = pulse;
      traceStart[u] = start;
      traceStop[u] = stop;
    end
  endtask

  task automatic traceBurst(int cycles, bit randCtl, bit stallAware);
    repeat (cycles) driveTraceCycle(randCtl, stallAware);
    @(negedge clk);
    timeTick = '0;
    tracePulse = '0;
    traceStart = '0;
    traceStop = '0;
    burstDone = 1'b1;
  endtask

  task automatic checkTracedEntry(traceEntry_u got);
    traceEntry_u exp;
    int u;
    int s;
    u = int'(got.pkt.unitId);
    s = int'(got.pkt.seq);
    if (!got.pkt.valid) begin
      failRun("DATA read returned an entry without its valid bit");
    end
    if (s >= capCount[u]) begin
      failRun($sformatf("unit %0d returned seq %0d that was never captured", u, s));
    end
    if (s <= lastSeq[u]) begin
      failRun($sformatf("unit %0d seq %0d does not follow seq %0d", u, s, lastSeq[u]));
    end
    exp.raw = '0;
    exp.pkt.valid = 1'b1;
    exp.pkt.unitId = got.pkt.unitId;
    exp.pkt.muxSel = expSel[u][s];
    exp.pkt.seq = got.pkt.seq;
    exp.pkt.data = expData[u][s];
    checkEntry("o_wbDat entry", got, exp);
    lastSeq[u] = s;
    readCount[u]++;
  endtask

  task automatic readWhileTracing();
    logic [31:0] d;
    traceEntry_u e;
    while (!burstDone) begin
      wbAccess(1'b0, int'(REG_DATA), '0, d);
      e.raw = d;
      if (d != '0) begin
        checkTracedEntry(e);
      end
    end
  endtask

  task automatic drainAndCheck(output int dropSum);
    logic [31:0] d;
    traceEntry_u e;
    int lvl;
    repeat (N + 2) @(negedge clk);
    lvl = 1;
    while (lvl != 0) begin
      wbAccess(1'b0, int'(REG_STATUS), '0, d);
      lvl = int'(d);
      if (lvl > DEPTH) begin
        failRun($sformatf("STATUS level %0d is above the buffer depth", lvl));
      end
      for (int i = 0; i < lvl; i++) begin
        wbAccess(1'b0, int'(REG_DATA), '0, d);
        e.raw = d;
        checkTracedEntry(e);
      end
    end
    wbAccess(1'b0, int'(REG_DATA), '0, d);
    checkWord("DATA after drain", d, '0);
    dropSum = 0;
    for (int u = 0; u < N; u++) begin
      wbAccess(1'b0, int'(REG_DROP_COUNT0) + u, '0, d);
      dropRead[u] = int'(d);
      dropSum += int'(d);
      checkWord($sformatf("entries read plus DROP_COUNT%0d", u),
                32'(readCount[u] + dropRead[u]), 32'(capCount[u]));
    end
  endtask

  // ************************************************************************
  // Tests
  // ************************************************************************

  task automatic testRegisters();
    logic [31:0] w;
    logic [31:0] d;
    int idx;
    for (int u = 0; u < N; u++) begin
      writeCfg(u, unitCfg_s'(randBits(CFG_W)));
    end
    for (int u = 0; u < N; u++) begin
      wbAccess(1'b0, int'(REG_UNIT_CFG0) + u, '0, d);
      checkWord($sformatf("UNIT_CFG%0d", u), d, 32'(cfgModel[u]));
      w = randBits(32);
      wbAccess(1'b1, int'(REG_DROP_COUNT0) + u, w, d);
      wbAccess(1'b0, int'(REG_DROP_COUNT0) + u, '0, d);
      checkWord($sformatf("DROP_COUNT%0d", u), d, '0);
    end
    wbAccess(1'b1, int'(REG_STATUS), randBits(32), d);
    wbAccess(1'b0, int'(REG_STATUS), '0, d);
    checkWord("STATUS", d, '0);
    wbAccess(1'b0, int'(REG_DATA), '0, d);
    checkWord("DATA on empty buffer", d, '0);
    repeat (16) begin
      idx = 10 + int'(randBits(6)) % 54;
      wbAccess(1'b1, idx, randBits(32), d);
      wbAccess(1'b0, idx, '0, d);
      checkWord($sformatf("unmapped register %0d", idx), d, '0);
    end
  endtask

  task automatic runTracing(int cycles, bit randCtl, bit stallAware);
    burstDone = 1'b0;
    fork
      traceBurst(cycles, randCtl, stallAware);
      readWhileTracing();
    join
  endtask

  initial begin
    unitCfg_s c;
    int dropSum;
    lfsrState = 16'd15657;
    arstN = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatIn = '0;
    hw = '0;
    timeTick = '0;
    traceStart = '0;
    traceStop = '0;
    tracePulse = '0;
    burstDone = 1'b1;
    stallSeen = 1'b0;

    applyReset();
    testRegisters();

    // Random control, some units left disabled
    applyReset();
    for (int r = 0; r < TRACE_ROUNDS; r++) begin
      for (int u = 0; u < N; u++) begin
        c.muxSel = SEL_W'(randBits(SEL_W));
        c.traceEn = randBits(2) != 0;
        c.stallMode = 1'b0;
        writeCfg(u, c);
      end
      runTracing(ROUND_CYCLES, 1'b1, 1'b0);
    end
    drainAndCheck(dropSum);

    // Overflow with no host reads
    applyReset();
    for (int u = 0; u < N; u++) begin
      writeCfg(u, '{muxSel: SEL_W'(randBits(SEL_W)), traceEn: 1'b1, stallMode: 1'b0});
    end
    burstDone = 1'b0;
    traceBurst(OVF_CYCLES, 1'b0, 1'b0);
    drainAndCheck(dropSum);
    if (dropSum == 0) begin
      failRun("overflow test produced no drops");
    end

    // Stall mode on units 0 and 1 only
    applyReset();
    for (int u = 0; u < N; u++) begin
      writeCfg(u, '{muxSel: SEL_W'(randBits(SEL_W)), traceEn: 1'b1, stallMode: u < 2});
    end
    runTracing(STALL_CYCLES, 1'b0, 1'b1);
    drainAndCheck(dropSum);
    for (int u = 0; u < 2; u++) begin
      checkWord($sformatf("DROP_COUNT%0d in stall mode", u), 32'(dropRead[u]), '0);
    end
    if (!stallSeen) begin
      failRun("o_stall never rose in the stall test");
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- traceFunnel.sv
/* Funnels the trace unit streams into one trace buffer. Round-robin grant,
   one entry per cycle, read by the register block from the head. */

`default_nettype none

`include "dfd_config.svh"

module traceFunnel
  import dfdPkg::*;
(
  input  logic               clk,
  input  logic               i_arstN,
  traceStreamIf.sink         i_streams [`DFD_NUM_UNITS],
  input  logic               i_pop,
  output logic [LEVEL_W-1:0] o_level,
  output traceEntry_u        o_head
);

  localparam int N = `DFD_NUM_UNITS;
  localparam int DEPTH = `DFD_FIFO_DEPTH;
  localparam int PTR_W = LEVEL_W - 1;

  logic [N-1:0] valids;
  logic [N-1:0] grant;
  traceEntry_s entries [N];
  logic [UNIT_ID_W-1:0] rrPtrQ;
  logic [UNIT_ID_W-1:0] winner;
  logic found;
  logic full;
  logic empty;
  logic push;
  logic pop;
  traceEntry_u pushEntry;
  logic [PTR_W:0] wrPtrQ;
  logic [PTR_W:0] rdPtrQ;
  traceEntry_u mem [DEPTH];

  for (genvar g = 0; g < N; g++) begin : gIn
    assign valids[g] = i_streams[g].valid;
    assign entries[g] = '{
      valid: 1'b1,
      unitId: UNIT_ID_W'(g),
      muxSel: i_streams[g].muxSel,
      seq: i_streams[g].seq,
      data: i_streams[g].data
    };
    assign i_streams[g].ready = grant[g];
  end

  // ************************************************************************
  // Round-robin arbiter
  // ************************************************************************

  always_comb begin
    logic [UNIT_ID_W-1:0] idx;
    found = 1'b0;
    winner = rrPtrQ;
    // First valid unit at or after the pointer
    for (int k = 0; k < N; k++) begin
      idx = rrPtrQ + UNIT_ID_W'(k);
      if (!found && valids[idx]) begin
        found = 1'b1;
        winner = idx;
      end
    end
  end

  assign grant = (found && !full) ? N'(1) << winner : '0;
  assign push = |grant;

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      rrPtrQ <= '0;
    end else if (push) begin
      rrPtrQ <= winner + 1'b1;
    end
  end

  // ************************************************************************
  // Trace buffer
  // ************************************************************************

  always_comb begin
    pushEntry.pkt = entries[winner];
  end

  assign o_level = wrPtrQ - rdPtrQ;
  assign full = o_level == LEVEL_W'(DEPTH);
  assign empty = o_level == '0;
  assign pop = i_pop && !empty;

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      wrPtrQ <= '0;
      rdPtrQ <= '0;
    end else begin
      if (push) begin
        wrPtrQ <= wrPtrQ + 1'b1;
      end
      if (pop) begin
        rdPtrQ <= rdPtrQ + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtrQ[PTR_W-1:0]] <= pushEntry;
    end
  end

  assign o_head = empty ? '0 : mem[rdPtrQ[PTR_W-1:0]];

  // A full buffer only shrinks by the pop of that cycle
  aNoPushFull: assert property (@(posedge clk) disable iff (!i_arstN)
    full |=> o_level == LEVEL_W'(DEPTH) - LEVEL_W'($past(pop)));

endmodule

`default_nettype wire

//--- traceUnit.sv
/* One trace instance. Selects a debug word, follows start/stop/pulse
   control, and offers each sample with its sequence number to the funnel. */

`default_nettype none

`include "dfd_config.svh"

module traceUnit
  import dfdPkg::*;
(
  input  logic                             clk,
  input  logic                             i_arstN,
  input  hwWord_t [`DFD_HW_WORDS-1:0]      i_hw,
  input  logic                             i_timeTick,
  input  logic                             i_traceStart,
  input  logic                             i_traceStop,
  input  logic                             i_tracePulse,
  unitCfgIf.unit                           io_cfg,
  traceStreamIf.source                     o_stream,
  output logic                             o_stall
);

  logic activeQ;
  logic capture;
  logic blocked;
  logic validQ;
  hwWord_t selWord;
  seq_t seqCntQ;
  logic [DROP_CNT_W-1:0] dropCntQ;
  logic [SEL_W-1:0] muxSelQ;
  seq_t seqQ;
  hwWord_t dataQ;

  assign selWord = i_hw[io_cfg.muxSel];
  // Tick needs the active flag, a pulse does not
  assign capture = io_cfg.traceEn && ((activeQ && i_timeTick) || i_tracePulse);
  assign blocked = validQ && !o_stream.ready;

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      activeQ <= 1'b0;
    end else if (i_traceStop) begin
      activeQ <= 1'b0;
    end else if (i_traceStart) begin
      activeQ <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge i_arstN) begin
    if (!i_arstN) begin
      validQ <= 1'b0;
      seqCntQ <= '0;
      dropCntQ <= '0;
    end else begin
      if (capture) begin
        seqCntQ <= seqCntQ + 1'b1;
      end
      if (capture && blocked) begin
        dropCntQ <= dropCntQ + 1'b1;
      end else if (capture) begin
        validQ <= 1'b1;
      end else if (o_stream.ready) begin
        validQ <= 1'b0;
      end
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (capture && !blocked) begin
      muxSelQ <= io_cfg.muxSel;
      seqQ <= seqCntQ;
      dataQ <= selWord;
    end
  end

  assign o_stream.valid = validQ;
  assign o_stream.muxSel = muxSelQ;
  assign o_stream.seq = seqQ;
  assign o_stream.data = dataQ;
  assign io_cfg.dropCount = dropCntQ;
  assign o_stall = blocked && io_cfg.stallMode;

  aHoldPayload: assert property (@(posedge clk) disable iff (!i_arstN)
    validQ && !o_stream.ready |=> validQ && $stable({muxSelQ, seqQ, dataQ}));

endmodule

`default_nettype wire
